// ==== source/bch_ctrl_pkg.sv ====
package bch_ctrl_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    localparam int CNT_W     = 12;
    localparam int ADDR_W    = 13;
    localparam int CFG_W     = 10;
    localparam int SYM_BITS  = 6;
    localparam int SYM_IDX_W = $clog2(SYM_BITS);

    // Correction capability per mode
    localparam int CAP_T8  = 8;
    localparam int CAP_T15 = 15;

    localparam int ERRCNT_W = $clog2(CAP_T15 + 1);
    localparam int EXPT_W   = ERRCNT_W + 1;

    // Parity bytes, GF(2^13) gives 13 parity bits per corrected bit
    localparam int GF_M          = 13;
    localparam int PAR_SLOTS_T8  = (CAP_T8 * GF_M + 7) / 8;
    localparam int PAR_SLOTS_T15 = (CAP_T15 * GF_M + 7) / 8;
    localparam int DEC_EXTRA_T8  = PAR_SLOTS_T8;
    localparam int DEC_EXTRA_T15 = PAR_SLOTS_T15;

    localparam int CHIEN_STEP = 3;

    // ------------------------------------------------------------
    // State encodings and mode word
    // ------------------------------------------------------------
    typedef enum logic [1:0] {ENC_IDLE, ENC_CALC, ENC_OUT, ENC_DONE} enc_state_t;

    typedef enum logic [1:0] {DEC_IDLE, DEC_CALC, DEC_HANDOFF} dec_state_t;

    typedef enum logic [1:0] {CHIEN_IDLE, CHIEN_CALC, CHIEN_OUT, CHIEN_DONE} chien_state_t;

    typedef struct packed {
        logic correct_en;
        logic dec;
        logic opt;
        logic en;
    } ecc_mode_t;

endpackage

// ==== source/wr_port_if.sv ====
`timescale 1ns/100ps

interface wr_port_if;
    import bch_ctrl_pkg::*;

    logic              req;
    logic              gnt;
    logic [ADDR_W-1:0] addr;
    // Completion cycle of the source, no request attached
    logic              last;

    modport src (
        output req,
        output addr,
        output last,
        input  gnt
    );

    modport arb (
        input  req,
        input  addr,
        input  last,
        output gnt
    );

endinterface

// ==== source/enc_sequencer.sv ====
`timescale 1ns/100ps

module enc_sequencer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  bch_ctrl_pkg::ecc_mode_t        mode_i,
    input  logic [bch_ctrl_pkg::CFG_W-1:0] cfg_i,
    input  logic                           wr_i,
    output logic                           data_avail_o,
    output logic                           last_o,
    output logic                           done_o,
    output logic                           busy_o,
    wr_port_if.src                         wr_port
);
    import bch_ctrl_pkg::*;

    enc_state_t       state;
    enc_state_t       state_nxt;
    logic [CNT_W-1:0] byte_cnt;
    logic [CNT_W-1:0] slot_cnt;
    logic [CNT_W-1:0] slot_max;
    logic             accept;
    logic             final_byte;
    logic             final_slot;

    assign slot_max   = mode_i.opt ? CNT_W'(PAR_SLOTS_T15 - 1) : CNT_W'(PAR_SLOTS_T8 - 1);
    assign accept     = mode_i.en && !mode_i.dec && wr_i
                        && (state == ENC_IDLE || state == ENC_CALC);
    assign final_byte = (byte_cnt == CNT_W'(cfg_i));
    assign final_slot = (slot_cnt == slot_max);

    always_comb
    begin
        state_nxt = state;
        case (state)
            ENC_IDLE, ENC_CALC:
            begin
                if (accept)
                    state_nxt = final_byte ? ENC_OUT : ENC_CALC;
            end
            ENC_OUT:
            begin
                // One parity slot per grant
                if (wr_port.gnt && final_slot)
                    state_nxt = ENC_DONE;
            end
            default:
                state_nxt = ENC_IDLE;
        endcase
        if (!mode_i.en)
            state_nxt = ENC_IDLE;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state        <= ENC_IDLE;
            byte_cnt     <= '0;
            slot_cnt     <= '0;
            data_avail_o <= 1'b0;
        end
        else
        begin
            state        <= state_nxt;
            data_avail_o <= accept;
            if (!mode_i.en || (accept && final_byte))
                byte_cnt <= '0;
            else if (accept)
                byte_cnt <= byte_cnt + 1'b1;
            if (state != ENC_OUT)
                slot_cnt <= '0;
            else if (wr_port.gnt)
                slot_cnt <= final_slot ? '0 : slot_cnt + 1'b1;
        end
    end

    assign last_o       = accept && final_byte;
    assign done_o       = (state == ENC_DONE);
    assign busy_o       = (state != ENC_IDLE);
    assign wr_port.req  = (state == ENC_OUT);
    assign wr_port.addr = ADDR_W'(slot_cnt);
    assign wr_port.last = done_o;

endmodule

// ==== source/dec_sequencer.sv ====
`timescale 1ns/100ps

module dec_sequencer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  bch_ctrl_pkg::ecc_mode_t        mode_i,
    input  logic [bch_ctrl_pkg::CFG_W-1:0] cfg_i,
    input  logic                           wr_i,
    input  logic                           chien_idle_i,
    output logic                           data_avail_o,
    output logic                           load_o,
    output logic [bch_ctrl_pkg::CNT_W-1:0] scan_start_o,
    output logic                           busy_o
);
    import bch_ctrl_pkg::*;

    dec_state_t       state;
    dec_state_t       state_nxt;
    logic [CNT_W-1:0] byte_cnt;
    logic [CNT_W-1:0] last_idx;
    logic [CNT_W-1:0] fold_rem;
    logic [CNT_W-1:0] fold_cnt;
    logic             accept;
    logic             final_byte;
    logic             fold_busy;

    // Index of the final received byte, data plus parity
    assign last_idx   = CNT_W'(cfg_i)
                        + (mode_i.opt ? CNT_W'(DEC_EXTRA_T15) : CNT_W'(DEC_EXTRA_T8));
    assign accept     = mode_i.en && mode_i.dec && wr_i
                        && (state == DEC_IDLE || state == DEC_CALC);
    assign final_byte = (byte_cnt == last_idx);
    assign fold_busy  = (fold_rem > CNT_W'(CHIEN_STEP));

    always_comb
    begin
        state_nxt = state;
        case (state)
            DEC_IDLE, DEC_CALC:
            begin
                if (accept)
                    state_nxt = final_byte ? DEC_HANDOFF : DEC_CALC;
            end
            DEC_HANDOFF:
            begin
                if (chien_idle_i && !fold_busy)
                    state_nxt = DEC_IDLE;
            end
            default:
                state_nxt = DEC_IDLE;
        endcase
        if (!mode_i.en)
            state_nxt = DEC_IDLE;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state        <= DEC_IDLE;
            byte_cnt     <= '0;
            data_avail_o <= 1'b0;
        end
        else
        begin
            state        <= state_nxt;
            data_avail_o <= accept;
            if (!mode_i.en || (accept && final_byte))
                byte_cnt <= '0;
            else if (accept)
                byte_cnt <= byte_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Scan start, one subtraction per cycle while bytes stream in
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (state == DEC_IDLE)
        begin
            fold_rem <= last_idx;
            fold_cnt <= '0;
        end
        else if (fold_busy)
        begin
            fold_rem <= fold_rem - CNT_W'(CHIEN_STEP);
            fold_cnt <= fold_cnt + 1'b1;
        end
    end

    assign scan_start_o = last_idx + fold_cnt;
    assign load_o       = mode_i.en && (state == DEC_HANDOFF) && chien_idle_i && !fold_busy;
    assign busy_o       = (state != DEC_IDLE);

endmodule

// ==== source/chien_sequencer.sv ====
`timescale 1ns/100ps

module chien_sequencer (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              en_i,
    input  logic                              correct_en_i,
    input  logic                              load_i,
    input  logic [bch_ctrl_pkg::CNT_W-1:0]    scan_start_i,
    input  logic                              detect_error_i,
    input  logic [bch_ctrl_pkg::SYM_BITS-1:0] error_data_i,
    input  logic                              err_flag_i,
    input  logic [bch_ctrl_pkg::EXPT_W-1:0]   err_expt_i,
    output logic                              idle_o,
    output logic                              done_o,
    output logic                              error_o,
    output logic                              correct_fail_o,
    wr_port_if.src                            wr_port
);
    import bch_ctrl_pkg::*;

    chien_state_t         state;
    chien_state_t         state_nxt;
    logic [CNT_W-1:0]     pos;
    logic [ERRCNT_W-1:0]  err_cnt;
    logic [EXPT_W-1:0]    expt_q;
    logic                 flag_q;
    logic                 corr_q;
    logic [SYM_BITS-1:0]  sym_q;
    logic [SYM_IDX_W-1:0] low_bit;
    logic                 stop;

    // Top bit of the expected count marks an uncorrectable block
    assign stop = !flag_q || !corr_q || expt_q[EXPT_W-1]
                  || ({1'b0, err_cnt} >= expt_q);

    always_comb
    begin
        state_nxt = state;
        case (state)
            CHIEN_IDLE:
            begin
                if (load_i)
                    state_nxt = CHIEN_CALC;
            end
            CHIEN_CALC:
            begin
                if (stop)
                    state_nxt = CHIEN_DONE;
                else if (detect_error_i)
                    state_nxt = CHIEN_OUT;
                else if (pos == '0)
                    state_nxt = CHIEN_DONE;
            end
            CHIEN_OUT:
            begin
                if (wr_port.gnt)
                    state_nxt = CHIEN_CALC;
            end
            default:
                state_nxt = CHIEN_IDLE;
        endcase
        if (!en_i)
            state_nxt = CHIEN_IDLE;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state   <= CHIEN_IDLE;
            pos     <= '0;
            err_cnt <= '0;
            expt_q  <= '0;
            flag_q  <= 1'b0;
            corr_q  <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (load_i)
            begin
                pos     <= scan_start_i;
                err_cnt <= '0;
                expt_q  <= err_expt_i;
                flag_q  <= err_flag_i;
                corr_q  <= correct_en_i;
            end
            else
            begin
                // Position holds while an error write waits
                if (state == CHIEN_CALC && !stop && !detect_error_i && pos != '0)
                    pos <= pos - 1'b1;
                if (state == CHIEN_OUT && wr_port.gnt)
                    err_cnt <= err_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == CHIEN_CALC && state_nxt == CHIEN_OUT)
            sym_q <= error_data_i;
    end

    // ------------------------------------------------------------
    // Byte address of the flagged bit
    // ------------------------------------------------------------
    always_comb
    begin
        low_bit = SYM_IDX_W'(SYM_BITS - 1);
        for (int i = SYM_BITS - 1; i >= 0; i--)
        begin
            if (sym_q[i])
                low_bit = SYM_IDX_W'(i);
        end
    end

    assign wr_port.addr = ADDR_W'(pos) * ADDR_W'(SYM_BITS)
                          + ADDR_W'(SYM_BITS - 1) - ADDR_W'(low_bit);
    assign wr_port.req  = (state == CHIEN_OUT);
    assign wr_port.last = done_o;

    assign idle_o         = (state == CHIEN_IDLE);
    assign done_o         = (state == CHIEN_DONE);
    assign error_o        = flag_q;
    assign correct_fail_o = corr_q && ({1'b0, err_cnt} < expt_q);

endmodule

// ==== source/wr_port_arbiter.sv ====
`timescale 1ns/100ps

module wr_port_arbiter (
    input  logic                            clk,
    input  logic                            rst_n,
    wr_port_if.arb                          enc_port,
    wr_port_if.arb                          chien_port,
    output logic                            wr_o,
    output logic [bch_ctrl_pkg::ADDR_W-1:0] addr_o,
    output logic                            done_o
);
    import bch_ctrl_pkg::*;

    logic prio_chien;
    logic enc_win;
    logic chien_win;

    // Round robin, the last winner yields on contention
    assign enc_win   = enc_port.req && !(chien_port.req && prio_chien);
    assign chien_win = chien_port.req && !enc_win;

    assign enc_port.gnt   = enc_win;
    assign chien_port.gnt = chien_win;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_o       <= 1'b0;
            done_o     <= 1'b0;
            prio_chien <= 1'b0;
        end
        else
        begin
            wr_o   <= enc_win || chien_win;
            done_o <= enc_port.last || chien_port.last;
            if (enc_win)
                prio_chien <= 1'b1;
            else if (chien_win)
                prio_chien <= 1'b0;
        end
    end

    // Holds the last written address
    always_ff @(posedge clk)
    begin
        if (enc_win)
            addr_o <= enc_port.addr;
        else if (chien_win)
            addr_o <= chien_port.addr;
    end

endmodule

// ==== source/bch_ctrl_top.sv ====
`timescale 1ns/100ps

module bch_ctrl_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [3:0]                        ecc_ctrl_i,
    input  logic [bch_ctrl_pkg::CFG_W-1:0]    ecc_cfg_i,
    input  logic                              ecc_wr_i,
    input  logic                              detect_error_i,
    input  logic [bch_ctrl_pkg::SYM_BITS-1:0] error_data_i,
    input  logic                              err_flag_i,
    input  logic [bch_ctrl_pkg::EXPT_W-1:0]   err_expt_i,
    output logic                              enc_data_avail_o,
    output logic                              enc_last_o,
    output logic                              dec_data_avail_o,
    output logic                              ecc_wr_o,
    output logic [bch_ctrl_pkg::ADDR_W-1:0]   error_addr_o,
    output logic                              ecc_done_o,
    output logic                              ecc_busy_o,
    output logic                              ecc_error_o,
    output logic                              correct_fail_o
);
    import bch_ctrl_pkg::*;

    ecc_mode_t        mode;
    logic             enc_busy;
    logic             dec_busy;
    logic             chien_idle;
    logic             chien_load;
    logic [CNT_W-1:0] scan_start;

    wr_port_if enc_port ();
    wr_port_if chien_port ();

    assign mode.en         = ecc_ctrl_i[0];
    assign mode.opt        = ecc_ctrl_i[1];
    assign mode.dec        = ecc_ctrl_i[2];
    assign mode.correct_en = ecc_ctrl_i[3];

    // Completion of both sources reaches the arbiter through last
    enc_sequencer u_enc (
        .clk          (clk),
        .rst_n        (rst_n),
        .mode_i       (mode),
        .cfg_i        (ecc_cfg_i),
        .wr_i         (ecc_wr_i),
        .data_avail_o (enc_data_avail_o),
        .last_o       (enc_last_o),
        .done_o       (),
        .busy_o       (enc_busy),
        .wr_port      (enc_port.src)
    );

    dec_sequencer u_dec (
        .clk          (clk),
        .rst_n        (rst_n),
        .mode_i       (mode),
        .cfg_i        (ecc_cfg_i),
        .wr_i         (ecc_wr_i),
        .chien_idle_i (chien_idle),
        .data_avail_o (dec_data_avail_o),
        .load_o       (chien_load),
        .scan_start_o (scan_start),
        .busy_o       (dec_busy)
    );

    chien_sequencer u_chien (
        .clk            (clk),
        .rst_n          (rst_n),
        .en_i           (mode.en),
        .correct_en_i   (mode.correct_en),
        .load_i         (chien_load),
        .scan_start_i   (scan_start),
        .detect_error_i (detect_error_i),
        .error_data_i   (error_data_i),
        .err_flag_i     (err_flag_i),
        .err_expt_i     (err_expt_i),
        .idle_o         (chien_idle),
        .done_o         (),
        .error_o        (ecc_error_o),
        .correct_fail_o (correct_fail_o),
        .wr_port        (chien_port.src)
    );

    wr_port_arbiter u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .enc_port   (enc_port.arb),
        .chien_port (chien_port.arb),
        .wr_o       (ecc_wr_o),
        .addr_o     (error_addr_o),
        .done_o     (ecc_done_o)
    );

    assign ecc_busy_o = enc_busy || dec_busy || !chien_idle;

endmodule

// ==== dv/bch_ctrl_tb.sv ====
`timescale 1ns/100ps

module bch_ctrl_tb;
    import bch_ctrl_pkg::*;

    localparam int ROW_W    = 15;
    localparam int MAX_ROWS = 16;
    localparam int TIMEOUT  = 5000;

    logic                clk;
    logic                rst_n;
    logic [3:0]          ecc_ctrl_i;
    logic [CFG_W-1:0]    ecc_cfg_i;
    logic                ecc_wr_i;
    logic                detect_error_i;
    logic [SYM_BITS-1:0] error_data_i;
    logic                err_flag_i;
    logic [EXPT_W-1:0]   err_expt_i;
    logic                enc_data_avail_o;
    logic                enc_last_o;
    logic                dec_data_avail_o;
    logic                ecc_wr_o;
    logic [ADDR_W-1:0]   error_addr_o;
    logic                ecc_done_o;
    logic                ecc_busy_o;
    logic                ecc_error_o;
    logic                correct_fail_o;

    logic [15:0] trace_mem [0:ROW_W*MAX_ROWS-1];
    logic [15:0] lfsr_state;
    int          det_off [4];
    int          det_dat [4];

    int enc_avail_n = 0;
    int enc_last_n  = 0;
    int last_at     = 0;
    int dec_avail_n = 0;
    int wr_n        = 0;
    int done_n      = 0;

    bch_ctrl_top DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Event counters, sampled on the edge
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (enc_data_avail_o)
                enc_avail_n++;
            if (enc_last_o)
            begin
                enc_last_n++;
                last_at = enc_avail_n;
            end
            if (dec_data_avail_o)
                dec_avail_n++;
            if (ecc_wr_o)
                wr_n++;
            if (ecc_done_o)
                done_n++;
        end
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b)
            lfsr_state = lfsr_state ^ 16'hB400;
        return b;
    endfunction

    function automatic int low_bit(input int sym);
        for (int i = 0; i < 6; i++)
        begin
            if (sym[i])
                return i;
        end
        return 5;
    endfunction

    task automatic check(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic timed_out(input string what);
        $display("timed out while waiting for %s", what);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic send_bytes(input int n, input logic gaps);
        int gap;
        for (int i = 0; i < n; i++)
        begin
            gap = 0;
            if (gaps)
            begin
                gap = int'(lfsr_bit());
                gap = gap * 2 + int'(lfsr_bit());
            end
            ecc_wr_i = 1'b0;
            repeat (gap)
            begin
                @(posedge clk);
                #1;
            end
            ecc_wr_i = 1'b1;
            @(posedge clk);
            #1;
        end
        ecc_wr_i = 1'b0;
    endtask

    task automatic wait_done(output int cycles);
        cycles = 0;
        while (!ecc_done_o)
        begin
            if (cycles >= TIMEOUT)
                timed_out("the done pulse");
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic wait_load();
        int n;
        n = 0;
        while (!DUT.chien_load)
        begin
            if (n >= TIMEOUT)
                timed_out("the Chien load");
            @(posedge clk);
            #1;
            n++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_error_write(input logic shared, input int exp_addr);
        int n;
        logic found;
        found = 1'b0;
        for (n = 0; n < TIMEOUT && !found; n++)
        begin
            @(posedge clk);
            #1;
            // Encode slot writes carry small addresses
            if (ecc_wr_o && !(shared && error_addr_o < 32))
            begin
                check("error_addr_o", int'(error_addr_o), exp_addr);
                found = 1'b1;
            end
        end
        if (!found)
            timed_out("an error write");
    endtask

    task automatic scan_detects(input int s, input int ndet, input logic shared,
                                output int p);
        int used;
        p = s;
        used = 0;
        for (int i = 0; i < ndet; i++)
        begin
            while (used < det_off[i])
            begin
                @(posedge clk);
                #1;
                used++;
                p--;
            end
            detect_error_i = 1'b1;
            error_data_i   = SYM_BITS'(det_dat[i]);
            wait_error_write(shared, 6 * p + 5 - low_bit(det_dat[i]));
            detect_error_i = 1'b0;
        end
    endtask

    // ------------------------------------------------------------
    // Block runs
    // ------------------------------------------------------------
    task automatic run_encode(input int cfg, input logic opt);
        int b_avail;
        int b_last;
        int b_wr;
        int b_done;
        int cycles;
        b_avail    = enc_avail_n;
        b_last     = enc_last_n;
        b_wr       = wr_n;
        b_done     = done_n;
        ecc_ctrl_i = {2'b00, opt, 1'b1};
        ecc_cfg_i  = CFG_W'(cfg);
        send_bytes(cfg + 1, 1'b1);
        wait_done(cycles);
        @(posedge clk);
        #1;
        check("enc_data_avail_o count", enc_avail_n - b_avail, cfg + 1);
        check("enc_last_o count", enc_last_n - b_last, 1);
        check("enc_last_o position", last_at - b_avail, cfg);
        check("ecc_wr_o count", wr_n - b_wr, opt ? 25 : 13);
        check("ecc_done_o count", done_n - b_done, 1);
    endtask

    task automatic run_decode(input int cfg, input logic opt, input logic corr,
                              input logic flag, input int expt, input int ndet,
                              input logic shared);
        int d;
        int t;
        int rem;
        int p;
        int cycles;
        int n;
        int b_avail;
        int b_wr;
        int b_done;
        logic stop;
        d   = cfg + (opt ? 25 : 13);
        t   = 0;
        rem = d;
        while (rem > 3)
        begin
            rem = rem - 3;
            t++;
        end
        b_avail    = dec_avail_n;
        b_wr       = wr_n;
        b_done     = done_n;
        ecc_ctrl_i = {corr, 1'b1, opt, 1'b1};
        ecc_cfg_i  = CFG_W'(cfg);
        err_flag_i = flag;
        err_expt_i = EXPT_W'(expt);
        send_bytes(d + 1, 1'b1);
        wait_load();
        check("dec_data_avail_o count", dec_avail_n - b_avail, d + 1);
        if (shared)
        begin
            // New encode runs alongside the scan, back to back so its
            // parity writes meet the late error writes on the port
            ecc_ctrl_i = {corr, 1'b0, opt, 1'b1};
            fork
                scan_detects(d + t, ndet, 1'b1, p);
                send_bytes(cfg + 1, 1'b0);
            join
            n = 0;
            while (ecc_busy_o)
            begin
                if (n >= TIMEOUT)
                    timed_out("both blocks to finish");
                @(posedge clk);
                #1;
                n++;
            end
            @(posedge clk);
            #1;
            check("ecc_wr_o count", wr_n - b_wr, (opt ? 25 : 13) + ndet);
        end
        else
        begin
            scan_detects(d + t, ndet, 1'b0, p);
            stop = !flag || !corr || expt >= 16 || ndet >= expt;
            if (stop)
            begin
                // A stopped walk ignores further detects
                detect_error_i = 1'b1;
                error_data_i   = SYM_BITS'(1);
            end
            wait_done(cycles);
            detect_error_i = 1'b0;
            check("walk cycles", cycles, stop ? 2 : p + 2);
            @(posedge clk);
            #1;
            check("ecc_wr_o count", wr_n - b_wr, ndet);
            check("ecc_done_o count", done_n - b_done, 1);
        end
        check("ecc_error_o", int'(ecc_error_o), int'(flag));
        check("correct_fail_o", int'(correct_fail_o), int'(corr && ndet < expt));
        check("ecc_busy_o", int'(ecc_busy_o), 0);
    endtask

    initial
    begin
        int base;
        int kind;
        rst_n          = 1'b0;
        ecc_ctrl_i     = '0;
        ecc_cfg_i      = '0;
        ecc_wr_i       = 1'b0;
        detect_error_i = 1'b0;
        error_data_i   = '0;
        err_flag_i     = 1'b0;
        err_expt_i     = '0;
        lfsr_state     = 16'd16;
        for (int i = 0; i < ROW_W * MAX_ROWS; i++)
            trace_mem[i] = 16'hffff;
        $readmemh("dv/bch_ctrl_trace.txt", trace_mem);

        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check("ecc_wr_o", int'(ecc_wr_o), 0);
        check("ecc_done_o", int'(ecc_done_o), 0);
        check("enc_data_avail_o", int'(enc_data_avail_o), 0);
        check("dec_data_avail_o", int'(dec_data_avail_o), 0);
        check("enc_last_o", int'(enc_last_o), 0);
        check("ecc_busy_o", int'(ecc_busy_o), 0);
        check("correct_fail_o", int'(correct_fail_o), 0);

        for (int r = 0; r < MAX_ROWS; r++)
        begin
            base = r * ROW_W;
            if (trace_mem[base] == 16'hffff)
                break;
            kind = int'(trace_mem[base]);
            for (int i = 0; i < 4; i++)
            begin
                det_off[i] = int'(trace_mem[base + 7 + 2 * i]);
                det_dat[i] = int'(trace_mem[base + 8 + 2 * i]);
            end
            if (kind == 0)
                run_encode(int'(trace_mem[base + 1]), trace_mem[base + 2][0]);
            else
                run_decode(int'(trace_mem[base + 1]), trace_mem[base + 2][0],
                           trace_mem[base + 3][0], trace_mem[base + 4][0],
                           int'(trace_mem[base + 5]), int'(trace_mem[base + 6]),
                           kind == 2);
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== dv/bch_ctrl_trace.txt ====
// kind(0 enc, 1 dec, 2 dec with encode alongside) cfg opt corr flag expt ndet
// then four pairs of detect offset and error_data, all hex
0 01F 0 0 0 00 0 00 00 00 00 00 00 00 00
0 00A 1 0 0 00 0 00 00 00 00 00 00 00 00
1 01F 0 1 1 04 0 00 00 00 00 00 00 00 00
1 01F 0 1 1 03 3 05 01 0A 04 14 20 00 00
1 020 1 1 1 05 2 03 06 10 03 00 00 00 00
1 01F 0 0 1 03 0 00 00 00 00 00 00 00 00
1 01F 0 1 0 03 0 00 00 00 00 00 00 00 00
1 01F 0 1 1 10 0 00 00 00 00 00 00 00 00
2 01F 1 1 1 04 4 02 01 08 02 0C 08 20 10
0 005 0 1 0 00 0 00 00 00 00 00 00 00 00

// ==== verilog.f ====
source/bch_ctrl_pkg.sv
source/wr_port_if.sv
source/enc_sequencer.sv
source/dec_sequencer.sv
source/chien_sequencer.sv
source/wr_port_arbiter.sv
source/bch_ctrl_top.sv
dv/bch_ctrl_tb.sv

// ==== Makefile ====
TOP = bch_ctrl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -o simv
	./obj_dir/simv | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
